// File: Bender.yml
package:
  name: vdec

sources:
  - src/vrv_isa_pkg.sv
  - src/vdec_ctrl_pkg.sv
  - src/pipe_stage.sv
  - src/vop_decode.sv
  - src/vctrl_gen.sv
  - src/vdec_top.sv
  - target: simulation
    files:
      - sim/vdec_checker.sv
      - sim/vdec_tb.sv

// File: filelist.f
src/vrv_isa_pkg.sv
src/vdec_ctrl_pkg.sv
src/pipe_stage.sv
src/vop_decode.sv
src/vctrl_gen.sv
src/vdec_top.sv
sim/vdec_checker.sv
sim/vdec_tb.sv

// File: sim/vdec_checker.sv
// decoder output checker
`timescale 1ns/1ps

module vdec_checker
  import vrv_isa_pkg::*, vdec_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  logic    in_ready,
  input  vinstr_t in_instr,
  input  logic    out_valid,
  input  logic    out_ready,
  input  vctrl_t  out_ctrl,
  output int      n_pass,
  output int      n_fail,
  output int      n_other,
  output int      n_pending
);

  // legal forms with vi in bit 2, vx/mvx in bit 1 and vv/mvv in bit 0
  typedef struct packed {
    vop_t       op;
    fu_t        fu;
    aluop_t     aluop;
    sign_t      sg;
    logic       cmp;
    logic [2:0] forms;
  } op_row_t;

  vctrl_t exp_q[$];
  vctrl_t held;
  logic   hold_d = 1'b0;
  logic   rst_d = 1'b0;
  int     field_errs;

  // funct6 codes as in the ratified vector spec
  // bit 6 of the key picks the OPM group
  function automatic op_row_t op_row(input logic opm, input logic [5:0] f6);
    case ({opm, f6})
      7'b0_000000: return '{OP_VADD,    ALU,  ADD,  SIGNED,          1'b0, 3'b111};
      7'b0_000010: return '{OP_VSUB,    ALU,  SUB,  SIGNED,          1'b0, 3'b011};
      7'b0_000011: return '{OP_VRSUB,   ALU,  SUB,  SIGNED,          1'b0, 3'b110};
      7'b0_000100: return '{OP_VMINU,   ALU,  MM,   UNSIGNED,        1'b0, 3'b011};
      7'b0_000101: return '{OP_VMIN,    ALU,  MM,   SIGNED,          1'b0, 3'b011};
      7'b0_000110: return '{OP_VMAXU,   ALU,  MM,   UNSIGNED,        1'b0, 3'b011};
      7'b0_000111: return '{OP_VMAX,    ALU,  MM,   SIGNED,          1'b0, 3'b011};
      7'b0_001001: return '{OP_VAND,    ALU,  AND,  UNSIGNED,        1'b0, 3'b111};
      7'b0_001010: return '{OP_VOR,     ALU,  OR,   UNSIGNED,        1'b0, 3'b111};
      7'b0_001011: return '{OP_VXOR,    ALU,  XOR,  UNSIGNED,        1'b0, 3'b111};
      7'b0_011000: return '{OP_VMSEQ,   ALU,  COMP, UNSIGNED,        1'b1, 3'b111};
      7'b0_011001: return '{OP_VMSNE,   ALU,  COMP, UNSIGNED,        1'b1, 3'b111};
      7'b0_011010: return '{OP_VMSLTU,  ALU,  COMP, UNSIGNED,        1'b1, 3'b011};
      7'b0_011011: return '{OP_VMSLT,   ALU,  COMP, SIGNED,          1'b1, 3'b011};
      7'b0_011100: return '{OP_VMSLEU,  ALU,  COMP, UNSIGNED,        1'b1, 3'b111};
      7'b0_011101: return '{OP_VMSLE,   ALU,  COMP, SIGNED,          1'b1, 3'b111};
      7'b0_011110: return '{OP_VMSGTU,  ALU,  COMP, UNSIGNED,        1'b1, 3'b110};
      7'b0_011111: return '{OP_VMSGT,   ALU,  COMP, SIGNED,          1'b1, 3'b110};
      7'b0_100101: return '{OP_VSLL,    ALU,  SLL,  UNSIGNED,        1'b0, 3'b111};
      7'b0_101000: return '{OP_VSRL,    ALU,  SRL,  UNSIGNED,        1'b0, 3'b111};
      7'b0_101001: return '{OP_VSRA,    ALU,  SRA,  UNSIGNED,        1'b0, 3'b111};
      7'b1_000000: return '{OP_VREDSUM, RED,  ADD,  SIGNED,          1'b0, 3'b001};
      7'b1_000001: return '{OP_VREDAND, RED,  AND,  UNSIGNED,        1'b0, 3'b001};
      7'b1_000010: return '{OP_VREDOR,  RED,  OR,   UNSIGNED,        1'b0, 3'b001};
      7'b1_000011: return '{OP_VREDXOR, RED,  XOR,  UNSIGNED,        1'b0, 3'b001};
      7'b1_011000: return '{OP_VMANDN,  MASK, AND,  UNSIGNED,        1'b0, 3'b001};
      7'b1_011001: return '{OP_VMAND,   MASK, AND,  UNSIGNED,        1'b0, 3'b001};
      7'b1_011010: return '{OP_VMOR,    MASK, OR,   UNSIGNED,        1'b0, 3'b001};
      7'b1_011011: return '{OP_VMXOR,   MASK, XOR,  UNSIGNED,        1'b0, 3'b001};
      7'b1_011100: return '{OP_VMORN,   MASK, OR,   UNSIGNED,        1'b0, 3'b001};
      7'b1_011101: return '{OP_VMNAND,  MASK, AND,  UNSIGNED,        1'b0, 3'b001};
      7'b1_011110: return '{OP_VMNOR,   MASK, OR,   UNSIGNED,        1'b0, 3'b001};
      7'b1_011111: return '{OP_VMXNOR,  MASK, XOR,  UNSIGNED,        1'b0, 3'b001};
      7'b1_100000: return '{OP_VDIVU,   DIV,  NOP,  UNSIGNED,        1'b0, 3'b011};
      7'b1_100001: return '{OP_VDIV,    DIV,  NOP,  SIGNED,          1'b0, 3'b011};
      7'b1_100010: return '{OP_VREMU,   DIV,  NOP,  UNSIGNED,        1'b0, 3'b011};
      7'b1_100011: return '{OP_VREM,    DIV,  NOP,  SIGNED,          1'b0, 3'b011};
      7'b1_100100: return '{OP_VMULHU,  MUL,  NOP,  UNSIGNED,        1'b0, 3'b011};
      7'b1_100101: return '{OP_VMUL,    MUL,  NOP,  SIGNED,          1'b0, 3'b011};
      7'b1_100110: return '{OP_VMULHSU, MUL,  NOP,  UNSIGNED_SIGNED, 1'b0, 3'b011};
      7'b1_100111: return '{OP_VMULH,   MUL,  NOP,  SIGNED,          1'b0, 3'b011};
      default:     return '{BAD_OP,     NONE, NOP,  UNSIGNED,        1'b0, 3'b000};
    endcase
  endfunction

  // reference decode of one instruction word
  function automatic vctrl_t model(input vinstr_t w);
    vctrl_t     e;
    op_row_t    r;
    logic [2:0] form;
    e = '0;
    r = op_row(1'b0, 6'b111111);
    form = 3'b000;
    e.dec.vclass = ILLEGAL_CLASS;
    e.dec.op = BAD_OP;
    e.dec.cfgsel = NOT_CFG;
    e.dec.funct3 = vfunct3_t'(w.funct3);
    e.dec.vm = w.vm;
    e.dec.vd = w.vd;
    e.dec.vs1 = w.vs1;
    e.dec.vs2 = w.vs2;
    e.fu = NONE;
    e.aluop = NOP;
    e.signedness = UNSIGNED;
    e.rs1_src = V;
    // OP-V major opcode
    if (w.opcode == 7'b1010111) begin
      case (w.funct3)
        3'b000: begin r = op_row(1'b0, w.funct6); form = 3'b001; end
        3'b100: begin r = op_row(1'b0, w.funct6); form = 3'b010; end
        3'b011: begin r = op_row(1'b0, w.funct6); form = 3'b100; end
        3'b010: begin r = op_row(1'b1, w.funct6); form = 3'b001; end
        3'b110: begin r = op_row(1'b1, w.funct6); form = 3'b010; end
        3'b111: begin
          e.dec.vclass = CFG_CLASS;
          case (w.funct6[5:4])
            2'b11:   e.dec.cfgsel = VSETIVLI;
            2'b10:   e.dec.cfgsel = VSETVL;
            default: e.dec.cfgsel = VSETVLI;
          endcase
          e.rs1_src = (e.dec.cfgsel == VSETIVLI) ? I : X;
        end
        default: ;
      endcase
      if ((r.forms & form) != 3'b000) begin
        e.dec.vclass = ARITH_CLASS;
        e.dec.op = r.op;
        e.fu = r.fu;
        e.aluop = r.aluop;
        e.signedness = r.sg;
        e.single_bit = r.cmp;
        e.wen = 2'b11;
        e.rs1_src = form[1] ? X : (form[2] ? I : V);
      end
    end else if ((w.opcode == 7'b0000111 || w.opcode == 7'b0100111) &&
                 (w.funct3 inside {3'b000, 3'b101, 3'b110})) begin
      e.dec.vclass = MEM_CLASS;
      e.rs1_src = X;
      // opcode bit 5 separates store from load
      if (w.opcode[5]) begin
        e.dec.store = 1'b1;
        e.fu = STORE_UNIT;
      end else begin
        e.dec.load = 1'b1;
        e.fu = LOAD_UNIT;
        e.wen = 2'b11;
      end
    end
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
    if (exp_v !== got_v) begin
      $display("ERR @ %0t: field %s expected %0h got %0h", $time, name, exp_v, got_v);
      field_errs++;
    end
  endtask

  task automatic check_output(input vctrl_t e, input vctrl_t g);
    field_errs = 0;
    compare_field("class", e.dec.vclass, g.dec.vclass);
    compare_field("op", e.dec.op, g.dec.op);
    compare_field("cfgsel", e.dec.cfgsel, g.dec.cfgsel);
    compare_field("funct3", e.dec.funct3, g.dec.funct3);
    compare_field("vm", e.dec.vm, g.dec.vm);
    compare_field("vd", e.dec.vd, g.dec.vd);
    compare_field("vs1", e.dec.vs1, g.dec.vs1);
    compare_field("vs2", e.dec.vs2, g.dec.vs2);
    compare_field("load", e.dec.load, g.dec.load);
    compare_field("store", e.dec.store, g.dec.store);
    compare_field("fu", e.fu, g.fu);
    compare_field("aluop", e.aluop, g.aluop);
    compare_field("signedness", e.signedness, g.signedness);
    compare_field("rs1_src", e.rs1_src, g.rs1_src);
    compare_field("wen", e.wen, g.wen);
    compare_field("single_bit", e.single_bit, g.single_bit);
    if (field_errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %0d: %s %s fu %s -> %s", n_pass + n_fail, e.dec.vclass.name(),
             e.dec.op.name(), e.fu.name(), (field_errs == 0) ? "ok" : "MISMATCH");
  endtask

  always @(posedge clk) begin
    vctrl_t exp_c;
    if (rst) begin
      n_pass = 0;
      n_fail = 0;
      n_other = 0;
      exp_q.delete();
    end
    // stages must come out of reset empty
    if (rst_d && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
      $display("reset failure at %0t: out_valid high or in_ready low after reset", $time);
      n_other++;
    end
    if (hold_d && !rst && (out_valid !== 1'b1 || out_ctrl !== held)) begin
      $display("stall failure at %0t: output dropped or changed while out_ready was low",
               $time);
      n_other++;
    end
    if (!rst && in_valid && in_ready) begin
      exp_q.push_back(model(in_instr));
    end
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("extra output at %0t: a result left with no instruction pending", $time);
        n_other++;
      end else begin
        exp_c = exp_q.pop_front();
        check_output(exp_c, out_ctrl);
      end
    end
    rst_d = rst;
    hold_d = !rst && out_valid && !out_ready;
    held = out_ctrl;
    n_pending = exp_q.size();
  end

endmodule

// File: sim/vdec_tb.sv
// vector decoder testbench
`timescale 1ns/1ps

module vdec_tb
  import vrv_isa_pkg::*, vdec_ctrl_pkg::*;
();

  localparam int          NUM_TESTS      = 200;
  localparam int          CLK_PERIOD     = 8;
  localparam int          TIMEOUT_CYCLES = 20;
  localparam logic [31:0] SEED           = 32'hdb84_d320;
  // funct3 values tried with kept funct6 codes, legal or not
  localparam logic [2:0]  ARITH_F3 [5]   = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110};

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  vinstr_t     in_instr;
  logic        out_valid;
  logic        out_ready;
  vctrl_t      out_ctrl;
  int          n_pass;
  int          n_fail;
  int          n_other;
  int          n_pending;
  logic [31:0] stim_state;
  logic [31:0] stall_state;

  always #(CLK_PERIOD / 2) clk = ~clk;

  vdec_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_ctrl  (out_ctrl)
  );

  vdec_checker chk_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_ctrl  (out_ctrl),
    .n_pass    (n_pass),
    .n_fail    (n_fail),
    .n_other   (n_other),
    .n_pending (n_pending)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // mix of kept ops, config, load/store and raw words
  task automatic make_instr(output vinstr_t w);
    int    pick;
    vopi_t fi;
    vopm_t fm;
    stim_state = lcg_next(stim_state);
    pick = int'(stim_state[31:16]) % 100;
    stim_state = lcg_next(stim_state);
    w = vinstr_t'(stim_state);
    stim_state = lcg_next(stim_state);
    if (pick < 50) begin
      w.opcode = VECTOR;
      w.funct3 = ARITH_F3[int'(stim_state[31:29]) % 5];
      if (stim_state[28]) begin
        fi = fi.first();
        repeat (int'(stim_state[27:16]) % fi.num()) fi = fi.next();
        w.funct6 = fi;
      end else begin
        fm = fm.first();
        repeat (int'(stim_state[27:16]) % fm.num()) fm = fm.next();
        w.funct6 = fm;
      end
    end else if (pick < 65) begin
      w.opcode = VECTOR;
      w.funct3 = OPCFG;
    end else if (pick < 80) begin
      w.opcode = stim_state[31] ? LOAD_FP : STORE_FP;
    end
  endtask

  // out_ready low on about 30% of cycles
  always @(posedge clk) begin
    #1;
    stall_state = lcg_next(stall_state);
    out_ready = (int'(stall_state[31:16]) % 100) >= 30;
  end

  initial begin
    vinstr_t w;
    logic    accepted;
    rst = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    out_ready = 1'b1;
    stim_state = SEED;
    stall_state = ~SEED;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      make_instr(w);
      in_valid = 1'b1;
      in_instr = w;
      do begin
        @(negedge clk);
        accepted = in_ready;
        @(posedge clk);
        #1;
      end while (!accepted);
    end
    in_valid = 1'b0;
    in_instr = '0;
    wait (n_pass + n_fail == NUM_TESTS);
    // a few idle cycles to catch late duplicates
    repeat (10) @(posedge clk);
    $display("tests %0d passed %0d failed %0d other errors %0d pending %0d",
             n_pass + n_fail, n_pass, n_fail, n_other, n_pending);
    if (n_fail == 0 && n_other == 0 && n_pending == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: only %0d of %0d results arrived before the time limit",
             n_pass + n_fail, NUM_TESTS);
    $display("Something failed");
    $finish;
  end

endmodule

// File: src/pipe_stage.sv
// valid/ready register stage
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,
  output logic     dn_valid,
  input  logic     dn_ready,
  output payload_t dn_data
);

  logic     full;
  payload_t data_q;

  // accept when empty or when the held item leaves this cycle
  assign up_ready = !full || dn_ready;
  assign dn_valid = full;
  assign dn_data  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (up_valid && up_ready) begin
      full <= 1'b1;
    end else if (dn_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (up_valid && up_ready) begin
      data_q <= up_data;
    end
  end

endmodule

// File: src/vctrl_gen.sv
// execution control generation
`timescale 1ns/1ps

module vctrl_gen
  import vrv_isa_pkg::*, vdec_ctrl_pkg::*;
(
  input  vdecode_t dec,
  output vctrl_t   ctrl
);

  fu_t        fu;
  aluop_t     aluop;
  sign_t      signedness;
  src_t       rs1_src;
  logic [1:0] wen;
  logic       single_bit;
  logic       is_arith;

  assign is_arith = (dec.vclass == ARITH_CLASS);

  // functional unit select
  always_comb begin
    fu = NONE;
    if (dec.load) begin
      fu = LOAD_UNIT;
    end else if (dec.store) begin
      fu = STORE_UNIT;
    end else if (is_arith) begin
      case (dec.op)
        OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR: fu = RED;
        OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU:      fu = MUL;
        OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:          fu = DIV;
        OP_VMANDN, OP_VMAND, OP_VMOR, OP_VMXOR,
        OP_VMORN, OP_VMNAND, OP_VMNOR, OP_VMXNOR:      fu = MASK;
        default:                                       fu = ALU;
      endcase
    end
  end

  always_comb begin
    case (dec.op)
      OP_VADD, OP_VREDSUM:                      aluop = ADD;
      OP_VSUB, OP_VRSUB:                        aluop = SUB;
      OP_VAND, OP_VREDAND, OP_VMAND,
      OP_VMANDN, OP_VMNAND:                     aluop = AND;
      OP_VOR, OP_VREDOR, OP_VMOR,
      OP_VMORN, OP_VMNOR:                       aluop = OR;
      OP_VXOR, OP_VREDXOR, OP_VMXOR, OP_VMXNOR: aluop = XOR;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: aluop = COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:     aluop = MM;
      OP_VSLL:                                  aluop = SLL;
      OP_VSRL:                                  aluop = SRL;
      OP_VSRA:                                  aluop = SRA;
      default:                                  aluop = NOP;
    endcase
  end

  always_comb begin
    case (dec.op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX,
      OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM,
      OP_VDIV, OP_VREM, OP_VMUL, OP_VMULH:      signedness = SIGNED;
      // vs2 signed, vs1 unsigned
      OP_VMULHSU:                               signedness = UNSIGNED_SIGNED;
      default:                                  signedness = UNSIGNED;
    endcase
  end

  // scalar register or immediate as first operand
  always_comb begin
    rs1_src = V;
    if (dec.load || dec.store) begin
      rs1_src = X;
    end else if (dec.vclass == CFG_CLASS) begin
      rs1_src = (dec.cfgsel == VSETIVLI) ? I : X;
    end else if (is_arith) begin
      if (dec.funct3 inside {OPIVX, OPMVX}) begin
        rs1_src = X;
      end else if (dec.funct3 == OPIVI) begin
        rs1_src = I;
      end
    end
  end

  assign wen = (dec.load || is_arith) ? 2'b11 : 2'b00;

  // compares write one mask bit per element
  assign single_bit = dec.op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
                                     OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT};

  assign ctrl = '{
    dec:        dec,
    fu:         fu,
    aluop:      aluop,
    signedness: signedness,
    rs1_src:    rs1_src,
    wen:        wen,
    single_bit: single_bit
  };

endmodule

// File: src/vdec_ctrl_pkg.sv
// vector decoder control types
package vdec_ctrl_pkg;
  import vrv_isa_pkg::*;

  typedef enum logic [5:0] {
    BAD_OP,
    // integer group
    OP_VADD, OP_VSUB, OP_VRSUB,
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    // mask/multiply group
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VMANDN, OP_VMAND, OP_VMOR, OP_VMXOR,
    OP_VMORN, OP_VMNAND, OP_VMNOR, OP_VMXNOR
  } vop_t;

  typedef enum logic [1:0] {
    ARITH_CLASS,
    CFG_CLASS,
    MEM_CLASS,
    ILLEGAL_CLASS
  } vclass_t;

  typedef enum logic [3:0] {
    ALU, RED, MUL, DIV, MASK, LOAD_UNIT, STORE_UNIT, NONE
  } fu_t;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, COMP, MM, SLL, SRL, SRA, NOP
  } aluop_t;

  typedef enum logic [1:0] {
    UNSIGNED, SIGNED, UNSIGNED_SIGNED
  } sign_t;

  typedef enum logic [1:0] {
    NOT_CFG, VSETVLI, VSETIVLI, VSETVL
  } cfgsel_t;

  // where the first scalar operand comes from
  typedef enum logic [1:0] {
    V, X, I
  } src_t;

  typedef struct packed {
    vclass_t              vclass;
    vop_t                 op;
    cfgsel_t              cfgsel;
    vfunct3_t             funct3;
    logic                 vm;
    logic [REG_IDX_W-1:0] vd;
    logic [REG_IDX_W-1:0] vs1;
    logic [REG_IDX_W-1:0] vs2;
    logic                 load;
    logic                 store;
  } vdecode_t;

  typedef struct packed {
    vdecode_t   dec;
    fu_t        fu;
    aluop_t     aluop;
    sign_t      signedness;
    src_t       rs1_src;
    logic [1:0] wen;
    logic       single_bit;
  } vctrl_t;

endpackage

// File: src/vdec_top.sv
// vector decoder top
`timescale 1ns/1ps

module vdec_top
  import vrv_isa_pkg::*, vdec_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  output logic    in_ready,
  input  vinstr_t in_instr,
  output logic    out_valid,
  input  logic    out_ready,
  output vctrl_t  out_ctrl
);

  vinstr_t  stage_instr;
  logic     stage_valid;
  logic     stage_ready;
  vdecode_t dec;
  vctrl_t   ctrl;

  pipe_stage #(.payload_t(vinstr_t)) in_stage_i (
    .clk      (clk),
    .rst      (rst),
    .up_valid (in_valid),
    .up_ready (in_ready),
    .up_data  (in_instr),
    .dn_valid (stage_valid),
    .dn_ready (stage_ready),
    .dn_data  (stage_instr)
  );

  vop_decode vop_decode_i (
    .instr (stage_instr),
    .dec   (dec)
  );

  vctrl_gen vctrl_gen_i (
    .dec  (dec),
    .ctrl (ctrl)
  );

  // decode is combinational, so the stages handshake directly
  pipe_stage #(.payload_t(vctrl_t)) out_stage_i (
    .clk      (clk),
    .rst      (rst),
    .up_valid (stage_valid),
    .up_ready (stage_ready),
    .up_data  (ctrl),
    .dn_valid (out_valid),
    .dn_ready (out_ready),
    .dn_data  (out_ctrl)
  );

endmodule

// File: src/vop_decode.sv
// vector instruction field and op decode
`timescale 1ns/1ps

module vop_decode
  import vrv_isa_pkg::*, vdec_ctrl_pkg::*;
(
  input  vinstr_t  instr,
  output vdecode_t dec
);

  opcode_t    opcode;
  vfunct3_t   funct3;
  mem_width_t width;
  vopi_t      f6_opi;
  vopm_t      f6_opm;
  logic       is_vec;
  logic       is_opi;
  logic       is_opm;
  logic       is_cfg;
  logic       width_ok;
  logic       is_load;
  logic       is_store;
  logic       f3_ok;
  vop_t       op;
  vclass_t    vclass;
  cfgsel_t    cfgsel;

  assign opcode = opcode_t'(instr.opcode);
  assign funct3 = vfunct3_t'(instr.funct3);
  assign width  = mem_width_t'(instr.funct3);
  assign f6_opi = vopi_t'(instr.funct6);
  assign f6_opm = vopm_t'(instr.funct6);

  assign is_vec = (opcode == VECTOR);
  assign is_opi = is_vec && (funct3 inside {OPIVV, OPIVX, OPIVI});
  assign is_opm = is_vec && (funct3 inside {OPMVV, OPMVX});
  assign is_cfg = is_vec && (funct3 == OPCFG);

  // only 8/16/32 bit elements are supported
  assign width_ok = width inside {WIDTH8, WIDTH16, WIDTH32};
  assign is_load  = (opcode == LOAD_FP) && width_ok;
  assign is_store = (opcode == STORE_FP) && width_ok;

  // bit 31 clear is vsetvli, else bit 30 picks vsetivli over vsetvl
  assign cfgsel = !is_cfg          ? NOT_CFG  :
                  !instr.funct6[5] ? VSETVLI  :
                  instr.funct6[4]  ? VSETIVLI : VSETVL;

  always_comb begin
    op    = BAD_OP;
    f3_ok = 1'b1;
    if (is_opi) begin
      case (f6_opi)
        VADD:   op = OP_VADD;
        VSUB:   op = OP_VSUB;
        VRSUB:  op = OP_VRSUB;
        VMINU:  op = OP_VMINU;
        VMIN:   op = OP_VMIN;
        VMAXU:  op = OP_VMAXU;
        VMAX:   op = OP_VMAX;
        VAND:   op = OP_VAND;
        VOR:    op = OP_VOR;
        VXOR:   op = OP_VXOR;
        VMSEQ:  op = OP_VMSEQ;
        VMSNE:  op = OP_VMSNE;
        VMSLTU: op = OP_VMSLTU;
        VMSLT:  op = OP_VMSLT;
        VMSLEU: op = OP_VMSLEU;
        VMSLE:  op = OP_VMSLE;
        VMSGTU: op = OP_VMSGTU;
        VMSGT:  op = OP_VMSGT;
        VSLL:   op = OP_VSLL;
        VSRL:   op = OP_VSRL;
        VSRA:   op = OP_VSRA;
        default: op = BAD_OP;
      endcase
      // no immediate form
      if (f6_opi inside {VSUB, VMINU, VMIN, VMAXU, VMAX, VMSLTU, VMSLT}) begin
        f3_ok = (funct3 != OPIVI);
      end
      // no vector-vector form
      if (f6_opi inside {VRSUB, VMSGTU, VMSGT}) begin
        f3_ok = (funct3 != OPIVV);
      end
    end else if (is_opm) begin
      case (f6_opm)
        VREDSUM: op = OP_VREDSUM;
        VREDAND: op = OP_VREDAND;
        VREDOR:  op = OP_VREDOR;
        VREDXOR: op = OP_VREDXOR;
        VMANDN:  op = OP_VMANDN;
        VMAND:   op = OP_VMAND;
        VMOR:    op = OP_VMOR;
        VMXOR:   op = OP_VMXOR;
        VMORN:   op = OP_VMORN;
        VMNAND:  op = OP_VMNAND;
        VMNOR:   op = OP_VMNOR;
        VMXNOR:  op = OP_VMXNOR;
        VDIVU:   op = OP_VDIVU;
        VDIV:    op = OP_VDIV;
        VREMU:   op = OP_VREMU;
        VREM:    op = OP_VREM;
        VMULHU:  op = OP_VMULHU;
        VMUL:    op = OP_VMUL;
        VMULHSU: op = OP_VMULHSU;
        VMULH:   op = OP_VMULH;
        default: op = BAD_OP;
      endcase
      // reductions and mask-logicals are vector-vector only
      if (instr.funct6[5:4] != 2'b10) begin
        f3_ok = (funct3 == OPMVV);
      end
    end
    if (!f3_ok) begin
      op = BAD_OP;
    end
  end

  always_comb begin
    if (is_cfg) begin
      vclass = CFG_CLASS;
    end else if (is_load || is_store) begin
      vclass = MEM_CLASS;
    end else if (op != BAD_OP) begin
      vclass = ARITH_CLASS;
    end else begin
      vclass = ILLEGAL_CLASS;
    end
  end

  assign dec = '{
    vclass: vclass,
    op:     op,
    cfgsel: cfgsel,
    funct3: funct3,
    vm:     instr.vm,
    vd:     instr.vd,
    vs1:    instr.vs1,
    vs2:    instr.vs2,
    load:   is_load,
    store:  is_store
  };

endmodule

// File: src/vrv_isa_pkg.sv
// vector instruction encoding
package vrv_isa_pkg;

  localparam int unsigned INSTR_W   = 32;
  localparam int unsigned REG_IDX_W = 5;

  // major opcodes used by the vector extension
  typedef enum logic [6:0] {
    VECTOR   = 7'b1010111,
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111
  } opcode_t;

  // funct3 categories of the OP-V major opcode
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // integer funct6 codes
  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VMSLEU = 6'b011100,
    VMSLE  = 6'b011101,
    VMSGTU = 6'b011110,
    VMSGT  = 6'b011111,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  // mask/multiply funct6 codes
  typedef enum logic [5:0] {
    VREDSUM = 6'b000000,
    VREDAND = 6'b000001,
    VREDOR  = 6'b000010,
    VREDXOR = 6'b000011,
    VMANDN  = 6'b011000,
    VMAND   = 6'b011001,
    VMOR    = 6'b011010,
    VMXOR   = 6'b011011,
    VMORN   = 6'b011100,
    VMNAND  = 6'b011101,
    VMNOR   = 6'b011110,
    VMXNOR  = 6'b011111,
    VDIVU   = 6'b100000,
    VDIV    = 6'b100001,
    VREMU   = 6'b100010,
    VREM    = 6'b100011,
    VMULHU  = 6'b100100,
    VMUL    = 6'b100101,
    VMULHSU = 6'b100110,
    VMULH   = 6'b100111
  } vopm_t;

  // element widths for unit-stride load/store
  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } mem_width_t;

  typedef struct packed {
    logic [5:0]           funct6;
    logic                 vm;
    logic [REG_IDX_W-1:0] vs2;
    logic [REG_IDX_W-1:0] vs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] vd;
    logic [6:0]           opcode;
  } vinstr_t;

endpackage
